/* Bender.yml */
package:
  name: ahb_mem_slave

sources:
  - include_dirs:
      - include
    files:
      - verilog/ahb_mem_pkg.sv
      - verilog/wait_state_timer.sv
      - verilog/byte_lane_mem.sv
      - verilog/ahb_xfer_fsm.sv
      - verilog/ahb_mem_slave.sv
  - target: test
    include_dirs:
      - include
    files:
      - dv/tb_ahb_mem_slave.sv

/* dv/tb_ahb_mem_slave.sv */
/*
 * table-driven testbench for the AHB-lite memory slave. rows and expected values
 * come from a byte model, then run one at a time and back to back.
 */
`include "ahb_mem_defs.svh"

module tb_ahb_mem_slave;
  timeunit 1ns;
  timeprecision 1ps;
  import ahb_mem_pkg::*;

  logic                   hclk;
  logic                   hresetn;
  logic                   hsel;
  logic [`AHB_ADDR_W-1:0] haddr;
  htrans_e                htrans;
  logic                   hwrite;
  hsize_e                 hsize;
  logic [`AHB_DATA_W-1:0] hwdata;
  logic                   hreadyout;
  logic                   hresp;
  logic [`AHB_DATA_W-1:0] hrdata;

  // stimulus table, one entry per row in each queue
  bit          t_sel[$];
  htrans_e     t_trans[$];
  bit          t_write[$];
  hsize_e      t_size[$];
  logic [31:0] t_addr[$];
  logic [31:0] t_wdata[$];
  logic [31:0] t_rdata[$];
  bit          t_resp[$];
  bit          t_chk[$];
  int          t_wait[$];

  // reference byte memory
  logic [7:0] model [`AHB_MEM_BYTES];
  integer     seed = 32'ha94a7a20;
  int         err_count;
  int         pass_count;
  int         fail_count;
  int         b2b_start;
  bit         table_ready;

  // single slave, so ready loops back
  ahb_mem_slave u_ahb_mem_slave (
    .hclk      (hclk),
    .hresetn   (hresetn),
    .hsel      (hsel),
    .haddr     (haddr),
    .htrans    (htrans),
    .hwrite    (hwrite),
    .hsize     (hsize),
    .hreadyin  (hreadyout),
    .hwdata    (hwdata),
    .hreadyout (hreadyout),
    .hresp     (hresp),
    .hrdata    (hrdata)
  );

  initial hclk = 1'b0;
  always #50 hclk = ~hclk;

  // range or alignment fault
  function automatic bit addr_bad(logic [31:0] a, hsize_e s);
    return a >= `AHB_MEM_BYTES || (s == HALF && a[0]) || (s == WORD && a[1:0] != 2'b00);
  endfunction

  // from the pins a ready okay cycle looks like idle
  function automatic xfer_state_e bus_phase(logic rdy, logic resp);
    if (resp) return rdy ? ST_ERR2 : ST_ERR1;
    return rdy ? ST_IDLE : ST_DATA;
  endfunction

  // expected results follow the model, which is updated in table order
  task automatic add_row(bit sel, htrans_e tr, bit wr, hsize_e sz, logic [31:0] a,
                         logic [31:0] wd);
    logic [31:0] rd;
    bit          act;
    bit          bad;
    int          n;
    act = sel && (tr == NONSEQ || tr == SEQ);
    bad = act && addr_bad(a, sz);
    n = (sz == WORD) ? 4 : (sz == HALF) ? 2 : 1;
    rd = '0;
    if (act && !bad) begin
      // big-endian, first byte in the top lane
      for (int k = 0; k < n; k++) begin
        if (wr) model[a + k] = wd[31 - 8*k -: 8];
        else rd[31 - 8*k -: 8] = model[a + k];
      end
    end
    t_sel.push_back(sel);
    t_trans.push_back(tr);
    t_write.push_back(wr);
    t_size.push_back(sz);
    t_addr.push_back(a);
    t_wdata.push_back(wd);
    t_rdata.push_back(rd);
    t_resp.push_back(bad);
    t_chk.push_back(act && !bad && !wr);
    t_wait.push_back(!act ? 0 : bad ? 1 : wr ? `AHB_WAIT_WRITE : `AHB_WAIT_READ);
  endtask

  task automatic build_table();
    for (int i = 0; i < `AHB_MEM_BYTES; i++) model[i] = 8'h00;
    // cleared after reset
    add_row(1, NONSEQ, 0, WORD, 'h000, 0);
    add_row(1, NONSEQ, 0, WORD, 'h1fc, 0);
    // each size, then partial overwrites of one word
    add_row(1, NONSEQ, 1, WORD, 'h010, $random(seed));
    add_row(1, SEQ,    0, WORD, 'h010, 0);
    add_row(1, NONSEQ, 1, BYTE, 'h011, 32'ha5000000);
    add_row(1, NONSEQ, 1, HALF, 'h012, $random(seed));
    add_row(1, NONSEQ, 0, WORD, 'h010, 0);
    add_row(1, SEQ,    0, BYTE, 'h013, 0);
    add_row(1, NONSEQ, 0, HALF, 'h010, 0);
    add_row(1, NONSEQ, 1, BYTE, 'h1ff, 32'h5a000000);
    // out of range, misaligned half, misaligned word
    add_row(1, NONSEQ, 1, WORD, 'h200, $random(seed));
    add_row(1, NONSEQ, 0, HALF, 'h031, 0);
    add_row(1, NONSEQ, 1, WORD, 'h012, $random(seed));
    // ignored transfers
    add_row(1, IDLE,   1, WORD, 'h010, $random(seed));
    add_row(1, BUSY,   1, WORD, 'h010, $random(seed));
    add_row(0, NONSEQ, 1, WORD, 'h010, $random(seed));
    add_row(1, NONSEQ, 0, WORD, 'h010, 0);
    add_row(1, NONSEQ, 0, WORD, 'h1fc, 0);
    // an out-of-range write would wrap onto address zero
    add_row(1, NONSEQ, 0, WORD, 'h000, 0);
    b2b_start = t_sel.size();
    // pipelined section
    add_row(1, NONSEQ, 1, WORD, 'h040, $random(seed));
    add_row(1, NONSEQ, 0, WORD, 'h040, 0);
    add_row(1, NONSEQ, 1, BYTE, 'h042, $random(seed));
    add_row(1, SEQ,    0, HALF, 'h042, 0);
    add_row(1, NONSEQ, 0, WORD, 'h046, 0);
    add_row(1, NONSEQ, 1, HALF, 'h046, $random(seed));
    add_row(1, IDLE,   0, WORD, 'h044, 0);
    add_row(1, NONSEQ, 0, WORD, 'h044, 0);
    add_row(1, NONSEQ, 0, WORD, 'h040, 0);
  endtask

  task automatic check_data(string name, logic [`AHB_DATA_W-1:0] exp,
                            logic [`AHB_DATA_W-1:0] got);
    if (got !== exp) begin
      $display("[ERROR] %s exp %h got %h", name, exp, got);
      err_count++;
    end
  endtask

  task automatic check_resp(string name, bit exp, bit got);
    if (got !== exp) begin
      $display("[ERROR] %s exp %h got %h", name, exp, got);
      err_count++;
    end
  endtask

  task automatic check_state(string name, xfer_state_e exp, xfer_state_e got);
    if (got !== exp) begin
      $display("[ERROR] %s exp %h got %h", name, exp, got);
      err_count++;
    end
  endtask

  task automatic drive_addr(int i);
    hsel   <= t_sel[i];
    htrans <= t_trans[i];
    hwrite <= t_write[i];
    hsize  <= t_size[i];
    haddr  <= t_addr[i];
  endtask

  task automatic run_row(int i, bit b2b);
    int          k;
    int          errs;
    bit          done;
    xfer_state_e exp_ph;
    errs = err_count;
    k = 0;
    done = 1'b0;
    if (!b2b || i == b2b_start) begin
      @(posedge hclk);
      drive_addr(i);
    end
    // accepting edge, write data for this row and address for the next
    @(posedge hclk);
    hwdata <= t_wdata[i];
    if (b2b && i + 1 < t_sel.size()) begin
      drive_addr(i + 1);
    end else begin
      htrans <= IDLE;
      hsel   <= 1'b0;
    end
    // walk the data phase up to the ready cycle
    while (!done) begin
      @(negedge hclk);
      if (k < t_wait[i]) exp_ph = t_resp[i] ? ST_ERR1 : ST_DATA;
      else exp_ph = t_resp[i] ? ST_ERR2 : ST_IDLE;
      check_state("hreadyout/hresp", exp_ph, bus_phase(hreadyout, hresp));
      if (hreadyout) done = 1'b1;
      else k++;
    end
    check_resp("hresp", t_resp[i], hresp);
    if (t_chk[i]) check_data("hrdata", t_rdata[i], hrdata);
    if (err_count == errs) pass_count++;
    else fail_count++;
    $display("row %0d %s %s @%h: %s", i, t_write[i] ? "wr" : "rd", t_size[i].name(),
             t_addr[i], (err_count == errs) ? "ok" : "mismatch");
  endtask

  // watchdog sized from the table length
  initial begin
    wait (table_ready);
    repeat (t_sel.size() * (`AHB_WAIT_WRITE + 4) + 40) @(posedge hclk);
    $display("timeout: the slave did not finish the table in time");
    $display("*** TEST FAILED ***");
    $finish;
  end

  initial begin
    hresetn = 1'b0;
    hsel    = 1'b0;
    haddr   = '0;
    htrans  = IDLE;
    hwrite  = 1'b0;
    hsize   = WORD;
    hwdata  = '0;
    err_count  = 0;
    pass_count = 0;
    fail_count = 0;
    build_table();
    table_ready = 1'b1;
    repeat (16) @(posedge hclk);
    hresetn <= 1'b1;
    @(negedge hclk);
    check_state("hreadyout/hresp", ST_IDLE, bus_phase(hreadyout, hresp));
    check_resp("hresp", 1'b0, hresp);
    if (err_count == 0) pass_count++;
    else fail_count++;
    $display("reset: %s", (err_count == 0) ? "ok" : "mismatch");
    for (int i = 0; i < b2b_start; i++) run_row(i, 1'b0);
    for (int i = b2b_start; i < t_sel.size(); i++) run_row(i, 1'b1);
    $display("tests passed %0d, failed %0d", pass_count, fail_count);
    if (fail_count == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

/* include/ahb_mem_defs.svh */
/*
 * bus widths, memory size and wait-state counts for the AHB-lite memory slave.
 * included by the package and by every module that sizes a port or a constant.
 */
`ifndef AHB_MEM_DEFS_SVH
`define AHB_MEM_DEFS_SVH

// AHB-lite bus widths
`define AHB_ADDR_W 32
`define AHB_DATA_W 32

// memory size in bytes
`define AHB_MEM_BYTES 512
// byte-address width into the memory, log2 of the size
`define AHB_MEM_AW 9

// wait cycles inserted before the final data-phase cycle
`define AHB_WAIT_WRITE 2
`define AHB_WAIT_READ 1

// wait counter width
// must hold the larger wait count
`define AHB_WAIT_W 4

`endif

/* sources.f */
+incdir+include
verilog/ahb_mem_pkg.sv
verilog/wait_state_timer.sv
verilog/byte_lane_mem.sv
verilog/ahb_xfer_fsm.sv
verilog/ahb_mem_slave.sv
dv/tb_ahb_mem_slave.sv

/* verilog/ahb_mem_pkg.sv */
/*
 * transfer, size and state enums plus address and count types for the memory slave.
 * modules import it inside their body and use scoped names in port lists.
 */
`include "ahb_mem_defs.svh"

package ahb_mem_pkg;

  // AHB htrans encoding
  typedef enum logic [1:0] {
    IDLE   = 2'b00,
    BUSY   = 2'b01,
    NONSEQ = 2'b10,
    SEQ    = 2'b11
  } htrans_e;

  // AHB hsize encoding, 32-bit bus only
  typedef enum logic [2:0] {
    BYTE = 3'b000,
    HALF = 3'b001,
    WORD = 3'b010
  } hsize_e;

  // transfer FSM states
  typedef enum logic [1:0] {
    ST_IDLE = 2'b00,
    ST_DATA = 2'b01,
    ST_ERR1 = 2'b10,
    ST_ERR2 = 2'b11
  } xfer_state_e;

  // byte address inside the memory
  typedef logic [`AHB_MEM_AW-1:0] mem_addr_t;
  // wait-state count
  typedef logic [`AHB_WAIT_W-1:0] wait_cnt_t;

endpackage

/* verilog/ahb_mem_slave.sv */
/*
 * AHB-lite memory slave top level. connects the transfer FSM, the wait-state
 * timer and the byte memory to loose AHB pins.
 */
`include "ahb_mem_defs.svh"

module ahb_mem_slave (
  input  logic                   hclk,
  input  logic                   hresetn,
  input  logic                   hsel,
  input  logic [`AHB_ADDR_W-1:0] haddr,
  input  ahb_mem_pkg::htrans_e   htrans,
  input  logic                   hwrite,
  input  ahb_mem_pkg::hsize_e    hsize,
  input  logic                   hreadyin,
  input  logic [`AHB_DATA_W-1:0] hwdata,
  output logic                   hreadyout,
  output logic                   hresp,
  output logic [`AHB_DATA_W-1:0] hrdata
);

  // fsm to timer
  logic timer_start;
  logic timer_write;
  logic timer_done;
  // fsm to memory
  logic capture;
  logic wr_commit;

  ahb_xfer_fsm u_fsm (
    .hclk        (hclk),
    .hresetn     (hresetn),
    .hsel        (hsel),
    .hreadyin    (hreadyin),
    .htrans      (htrans),
    .hwrite      (hwrite),
    .hsize       (hsize),
    .haddr       (haddr),
    .timer_done  (timer_done),
    .hreadyout   (hreadyout),
    .hresp       (hresp),
    .timer_start (timer_start),
    .timer_write (timer_write),
    .capture     (capture),
    .wr_commit   (wr_commit)
  );

  wait_state_timer u_timer (
    .hclk        (hclk),
    .hresetn     (hresetn),
    .timer_start (timer_start),
    .timer_write (timer_write),
    .timer_done  (timer_done)
  );

  byte_lane_mem u_mem (
    .hclk      (hclk),
    .hresetn   (hresetn),
    .capture   (capture),
    .wr_commit (wr_commit),
    .haddr     (haddr),
    .hsize     (hsize),
    .hwdata    (hwdata),
    .hrdata    (hrdata)
  );

endmodule

/* verilog/ahb_xfer_fsm.sv */
/*
 * AHB-lite transfer FSM. accepts address phases, decodes range and alignment
 * errors, and drives hreadyout/hresp plus the timer and memory strobes.
 */
`include "ahb_mem_defs.svh"

module ahb_xfer_fsm (
  input  logic                   hclk,
  input  logic                   hresetn,
  input  logic                   hsel,
  input  logic                   hreadyin,
  input  ahb_mem_pkg::htrans_e   htrans,
  input  logic                   hwrite,
  input  ahb_mem_pkg::hsize_e    hsize,
  input  logic [`AHB_ADDR_W-1:0] haddr,
  input  logic                   timer_done,
  output logic                   hreadyout,
  output logic                   hresp,
  output logic                   timer_start,
  output logic                   timer_write,
  output logic                   capture,
  output logic                   wr_commit
);
  import ahb_mem_pkg::*;

  // first byte address past the memory
  localparam logic [`AHB_ADDR_W-1:0] mem_limit = `AHB_MEM_BYTES;

  xfer_state_e state;
  xfer_state_e state_nxt;
  xfer_state_e accept_state;
  logic        accept;
  logic        addr_err;
  // direction of the transfer in its data phase
  logic        dir_q;

  // valid address phase, sampled only when no data phase of ours is stalled
  assign accept = hsel && hreadyin && hreadyout && (htrans == NONSEQ || htrans == SEQ);

  // out of range, or not aligned to the size
  always_comb begin
    addr_err = (haddr >= mem_limit);
    case (hsize)
      BYTE: ;
      HALF: if (haddr[0]) addr_err = 1'b1;
      WORD: if (haddr[1:0] != 2'b00) addr_err = 1'b1;
      default: addr_err = 1'b1;
    endcase
  end

  assign accept_state = !accept ? ST_IDLE : (addr_err ? ST_ERR1 : ST_DATA);

  always_comb begin
    case (state)
      // stay until the timer releases the final cycle
      ST_DATA: state_nxt = timer_done ? accept_state : ST_DATA;
      // error response is always two cycles
      ST_ERR1: state_nxt = ST_ERR2;
      default: state_nxt = accept_state;
    endcase
  end

  always_ff @(posedge hclk or negedge hresetn) begin
    if (!hresetn) begin
      state <= ST_IDLE;
      dir_q <= 1'b0;
    end else begin
      state <= state_nxt;
      if (timer_start) begin
        dir_q <= hwrite;
      end
    end
  end

  // ready low during wait states and in the first error cycle
  always_comb begin
    case (state)
      ST_DATA: hreadyout = timer_done;
      ST_ERR1: hreadyout = 1'b0;
      default: hreadyout = 1'b1;
    endcase
  end

  assign hresp = (state == ST_ERR1) || (state == ST_ERR2);

  // okay transfers start the timer and get their address sampled
  assign timer_start = accept && !addr_err;
  assign timer_write = hwrite;
  assign capture     = timer_start;

  // write lands at the end of the last data-phase cycle
  assign wr_commit = (state == ST_DATA) && timer_done && dir_q;

  // the timer only counts inside an okay data phase
  a_no_resp_in_wait : assert property (@(posedge hclk) disable iff (!hresetn)
    !timer_done |-> !hresp)
    else $error("hresp high while the wait timer is still counting");

  // write lands on the edge that ends its stretched data phase
  a_commit_timing : assert property (@(posedge hclk) disable iff (!hresetn)
    timer_start && hwrite |-> ##(`AHB_WAIT_WRITE + 1) wr_commit)
    else $error("write commit not at the end of its data phase");

endmodule

/* verilog/byte_lane_mem.sv */
/*
 * byte-wide slave memory, cleared on reset. samples the address phase on capture,
 * commits big-endian writes on wr_commit and forms hrdata combinationally.
 */
`include "ahb_mem_defs.svh"

module byte_lane_mem (
  input  logic                   hclk,
  input  logic                   hresetn,
  input  logic                   capture,
  input  logic                   wr_commit,
  input  logic [`AHB_ADDR_W-1:0] haddr,
  input  ahb_mem_pkg::hsize_e    hsize,
  input  logic [`AHB_DATA_W-1:0] hwdata,
  output logic [`AHB_DATA_W-1:0] hrdata
);
  import ahb_mem_pkg::*;

  logic [7:0] mem [`AHB_MEM_BYTES];

  // address phase held through the data phase
  mem_addr_t addr_q;
  hsize_e    size_q;

  // addresses of the four lanes, lane 0 is the msb byte
  mem_addr_t a0;
  mem_addr_t a1;
  mem_addr_t a2;
  mem_addr_t a3;
  // last byte touched, one bit wider so overflow shows
  logic [`AHB_MEM_AW:0] last_byte;

  always_ff @(posedge hclk or negedge hresetn) begin
    if (!hresetn) begin
      addr_q <= '0;
      size_q <= BYTE;
    end else if (capture) begin
      addr_q <= haddr[`AHB_MEM_AW-1:0];
      size_q <= hsize;
    end
  end

  assign a0 = addr_q;
  assign a1 = addr_q + mem_addr_t'(1);
  assign a2 = addr_q + mem_addr_t'(2);
  assign a3 = addr_q + mem_addr_t'(3);

  // big-endian write, hwdata[31:24] goes to the transfer address
  always_ff @(posedge hclk or negedge hresetn) begin
    if (!hresetn) begin
      for (int i = 0; i < `AHB_MEM_BYTES; i++) begin
        mem[i] <= 8'h00;
      end
    end else if (wr_commit) begin
      mem[a0] <= hwdata[31:24];
      if (size_q != BYTE) begin
        mem[a1] <= hwdata[23:16];
      end
      if (size_q == WORD) begin
        mem[a2] <= hwdata[15:8];
        mem[a3] <= hwdata[7:0];
      end
    end
  end

  // read path has no register, so a read right after a write sees it
  always_comb begin
    hrdata = '0;
    hrdata[31:24] = mem[a0];
    if (size_q != BYTE) begin
      hrdata[23:16] = mem[a1];
    end
    if (size_q == WORD) begin
      hrdata[15:8] = mem[a2];
      hrdata[7:0]  = mem[a3];
    end
  end

  always_comb begin
    case (size_q)
      HALF:    last_byte = {1'b0, addr_q} + 1'b1;
      WORD:    last_byte = {1'b0, addr_q} + 2'd3;
      default: last_byte = {1'b0, addr_q};
    endcase
  end

  // FSM error decode has to keep every committed write inside the array
  a_commit_range : assert property (@(posedge hclk) disable iff (!hresetn)
    wr_commit |-> last_byte < (`AHB_MEM_AW+1)'(`AHB_MEM_BYTES))
    else $error("write commit runs past the end of memory");

endmodule

/* verilog/wait_state_timer.sv */
/*
 * wait-state down-counter. loads the write or read wait count on timer_start
 * and reports done once the count has reached zero.
 */
`include "ahb_mem_defs.svh"

module wait_state_timer (
  input  logic hclk,
  input  logic hresetn,
  input  logic timer_start,
  input  logic timer_write,
  output logic timer_done
);
  import ahb_mem_pkg::*;

  wait_cnt_t count;

  always_ff @(posedge hclk or negedge hresetn) begin
    if (!hresetn) begin
      count <= '0;
    end else if (timer_start) begin
      // direction picks the stretch
      count <= timer_write ? wait_cnt_t'(`AHB_WAIT_WRITE) : wait_cnt_t'(`AHB_WAIT_READ);
    end else if (count != '0) begin
      count <= count - 1'b1;
    end
  end

  // zero wait count gives done in the first data cycle
  assign timer_done = (count == '0);

  // a new stretch only starts once the last one has run out
  a_start_when_idle : assert property (@(posedge hclk) disable iff (!hresetn)
    timer_start |-> timer_done)
    else $error("wait timer restarted while still counting");

endmodule
